// ==== verilog/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int nibble_w  = 4;
  localparam int addr_w    = 12;
  localparam int instr_w   = 12;
  localparam int ram_depth = 4096;

  localparam logic [addr_w-1:0] reset_pc = 12'h100;  // first fetch address.

  // r operand codes.
  localparam logic [1:0] r_a  = 2'd0;
  localparam logic [1:0] r_b  = 2'd1;
  localparam logic [1:0] r_mx = 2'd2;
  localparam logic [1:0] r_my = 2'd3;

  // alu operation selects.
  localparam logic [2:0] op_ld   = 3'd0;
  localparam logic [2:0] op_add  = 3'd1;
  localparam logic [2:0] op_and  = 3'd2;
  localparam logic [2:0] op_rlc  = 3'd3;
  localparam logic [2:0] op_rrc  = 3'd4;
  localparam logic [2:0] op_pass = 3'd5;

  // instruction lengths in clocks.
  localparam logic [2:0] cyc_short = 3'd5;
  localparam logic [2:0] cyc_long  = 3'd7;

  // ------------------------------
  // opcode base words
  // ------------------------------
  localparam logic [instr_w-1:0] opc_rlc    = 12'hAF0;  // r twice, bits 3:2 and 1:0.
  localparam logic [instr_w-1:0] opc_rrc    = 12'hE8C;  // r in bits 1:0.
  localparam logic [instr_w-1:0] opc_ld_ri  = 12'hE00;  // r in 5:4, imm in 3:0.
  localparam logic [instr_w-1:0] opc_add_ri = 12'hC00;
  localparam logic [instr_w-1:0] opc_and_ri = 12'hC80;
  localparam logic [instr_w-1:0] opc_ld_x   = 12'hB00;  // byte in 7:0.
  localparam logic [instr_w-1:0] opc_ld_y   = 12'h800;
  localparam logic [instr_w-1:0] opc_nop5   = 12'hFFB;
  localparam logic [instr_w-1:0] opc_nop7   = 12'hFFF;

endpackage

`default_nettype wire

// ==== verilog/cpu_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_alu import cpu_pkg::*; (
  input  wire  [2:0]          op,
  input  wire  [nibble_w-1:0] operand,
  input  wire  [nibble_w-1:0] imm,
  input  wire                 carry_in,
  output logic [nibble_w-1:0] result,
  output logic                carry_out,
  output logic                zero_out
);

  always_comb begin
    result    = operand;
    carry_out = carry_in;  // kept unless the op says otherwise.
    case (op)
      op_ld: begin
        result = imm;
      end
      op_add: begin
        {carry_out, result} = {1'b0, operand} + {1'b0, imm};
      end
      op_and: begin
        result = operand & imm;
      end
      op_rlc: begin
        // carry enters bit 0, bit 3 leaves.
        {carry_out, result} = {operand, carry_in};
      end
      op_rrc: begin
        {result, carry_out} = {carry_in, operand};  // mirror of rlc.
      end
      op_pass: begin
        result = operand;
      end
      default: begin
        result = operand;
      end
    endcase
  end

  assign zero_out = (result == '0);

endmodule

`default_nettype wire

// ==== verilog/cpu_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_regs import cpu_pkg::*; (
  input  wire                 clk,
  input  wire                 rst,
  input  wire                 pc_inc,
  input  wire                 a_we,
  input  wire                 b_we,
  input  wire                 x_we,
  input  wire                 y_we,
  input  wire                 flag_we,
  input  wire  [addr_w-1:0]   xy_byte,
  input  wire  [nibble_w-1:0] wdata,
  input  wire                 carry_in,
  input  wire                 zero_in,
  output logic [addr_w-1:0]   pc,
  output logic [addr_w-1:0]   x,
  output logic [addr_w-1:0]   y,
  output logic [nibble_w-1:0] a,
  output logic [nibble_w-1:0] b,
  output logic                carry,
  output logic                zero
);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= reset_pc;
      a     <= '0;
      b     <= '0;
      x     <= '0;
      y     <= '0;
      carry <= 1'b0;
      zero  <= 1'b0;
    end else begin
      if (pc_inc)
        pc <= pc + 1'b1;
      if (a_we)
        a <= wdata;
      if (b_we)
        b <= wdata;
      // index loads keep the upper nibble.
      if (x_we)
        x <= {x[addr_w-1:8], xy_byte[7:0]};
      if (y_we)
        y <= {y[addr_w-1:8], xy_byte[7:0]};
      if (flag_we) begin
        carry <= carry_in;
        zero  <= zero_in;
      end
    end
  end

  // sequencer writes one register per instruction.
  a_one_we: assert property (@(posedge clk) disable iff (rst)
    $onehot0({a_we, b_we, x_we, y_we}));

endmodule

`default_nettype wire

// ==== verilog/cpu_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_ram import cpu_pkg::*; (
  input  wire                 clk,
  input  wire                 re,
  input  wire                 we,
  input  wire  [addr_w-1:0]   addr,
  input  wire  [nibble_w-1:0] wdata,
  output logic [nibble_w-1:0] rdata
);

  logic [nibble_w-1:0] mem [ram_depth];

  // read sees the old word on a same-address write.
  always_ff @(posedge clk) begin
    if (we)
      mem[addr] <= wdata;
    if (re)
      rdata <= mem[addr];
  end

endmodule

`default_nettype wire

// ==== verilog/cpu_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
  input  wire                 clk,
  input  wire                 rst,
  input  wire  [instr_w-1:0]  rom_data,
  input  wire  [nibble_w-1:0] ram_rdata,
  input  wire  [addr_w-1:0]   pc,
  input  wire  [nibble_w-1:0] a,
  input  wire  [nibble_w-1:0] b,
  input  wire  [addr_w-1:0]   x,
  input  wire  [addr_w-1:0]   y,
  input  wire                 carry,
  output logic [addr_w-1:0]   rom_addr,
  output logic                ram_re,
  output logic                ram_we,
  output logic [addr_w-1:0]   ram_addr,
  output logic [nibble_w-1:0] ram_wdata,
  output logic                pc_inc,
  output logic                a_we,
  output logic                b_we,
  output logic                x_we,
  output logic                y_we,
  output logic                flag_we,
  output logic [nibble_w-1:0] wdata,
  output logic [addr_w-1:0]   xy_byte,
  output logic                carry_in,
  output logic                zero_in,
  output logic                instr_done
);

  logic [2:0]          cnt;  // 1 is the fetch cycle.
  logic [instr_w-1:0]  ir;
  logic [nibble_w-1:0] operand;
  logic [1:0]          r_sel;
  logic [2:0]          alu_op;
  logic [nibble_w-1:0] alu_result;
  logic                alu_carry;
  logic                alu_zero;

  // ------------------------------
  // decode
  // ------------------------------
  wire first = (cnt == 3'd1);
  wire [instr_w-1:0] word = first ? rom_data : ir;  // rom word until latched.

  wire is_rlc  = (word[11:4] == opc_rlc[11:4]) && (word[3:2] == word[1:0]);
  wire is_rrc  = (word[11:2] == opc_rrc[11:2]);
  wire is_ld   = (word[11:6] == opc_ld_ri[11:6]);
  wire is_add  = (word[11:6] == opc_add_ri[11:6]);
  wire is_and  = (word[11:6] == opc_and_ri[11:6]);
  wire is_ld_x = (word[11:8] == opc_ld_x[11:8]);
  wire is_ld_y = (word[11:8] == opc_ld_y[11:8]);
  wire is_nop7 = (word == opc_nop7);

  wire uses_r = is_rlc || is_rrc || is_ld || is_add || is_and;
  wire mem_op = uses_r && (r_sel == r_mx || r_sel == r_my);
  wire [2:0] len = (is_rlc || is_add || is_and || is_nop7) ? cyc_long : cyc_short;
  wire last = (cnt == len);

  always_comb begin
    if (is_rlc || is_rrc)
      r_sel = word[1:0];
    else
      r_sel = word[5:4];
  end

  always_comb begin
    if (is_rlc)
      alu_op = op_rlc;
    else if (is_rrc)
      alu_op = op_rrc;
    else if (is_ld)
      alu_op = op_ld;
    else if (is_add)
      alu_op = op_add;
    else if (is_and)
      alu_op = op_and;
    else
      alu_op = op_pass;  // anything else runs as nop5.
  end

  // ------------------------------
  // sequencer
  // ------------------------------
  always_ff @(posedge clk) begin
    if (rst)
      cnt <= 3'd1;
    else if (last)
      cnt <= 3'd1;
    else
      cnt <= cnt + 3'd1;
  end

  always_ff @(posedge clk) begin
    if (first)
      ir <= rom_data;
    if (cnt == 3'd2)
      operand <= mem_op ? ram_rdata : ((r_sel == r_b) ? b : a);
  end

  cpu_alu u_alu (
    .op        (alu_op),
    .operand   (operand),
    .imm       (ir[3:0]),
    .carry_in  (carry),
    .result    (alu_result),
    .carry_out (alu_carry),
    .zero_out  (alu_zero)
  );

  assign rom_addr  = pc;
  assign ram_re    = first && !rst && mem_op;  // no fetch while held in reset.
  assign ram_addr  = (r_sel == r_my) ? y : x;
  assign ram_we    = last && mem_op;
  assign ram_wdata = alu_result;

  assign pc_inc     = last;
  assign instr_done = last;
  assign a_we       = last && uses_r && (r_sel == r_a);
  assign b_we       = last && uses_r && (r_sel == r_b);
  assign x_we       = last && is_ld_x;
  assign y_we       = last && is_ld_y;
  assign flag_we    = last && (is_rlc || is_rrc || is_add || is_and);
  assign wdata      = alu_result;
  assign xy_byte    = {{(addr_w - 8){1'b0}}, ir[7:0]};
  assign carry_in   = alu_carry;
  assign zero_in    = alu_zero;

  // a reset cycle always restarts at fetch.
  a_no_done_in_rst: assert property (@(posedge clk) rst |=> !instr_done);
  // a ram write needs the operand read at fetch.
  a_we_mem_only: assert property (@(posedge clk) disable iff (rst)
    ram_we |-> ($past(ram_re, cyc_short - 1) || $past(ram_re, cyc_long - 1)));

endmodule

`default_nettype wire

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu import cpu_pkg::*; (
  input  wire                 clk,
  input  wire                 rst,
  input  wire  [instr_w-1:0]  rom_data,
  output wire  [addr_w-1:0]   rom_addr,
  output wire  [addr_w-1:0]   out_pc,
  output wire  [nibble_w-1:0] out_a,
  output wire  [nibble_w-1:0] out_b,
  output wire  [addr_w-1:0]   out_x,
  output wire  [addr_w-1:0]   out_y,
  output wire                 out_carry,
  output wire                 out_zero,
  output wire                 instr_done,
  output wire                 io_we,       // ram write bus, also seen by peripherals.
  output wire  [addr_w-1:0]   io_addr,
  output wire  [nibble_w-1:0] io_wdata
);

  wire                ram_re;
  wire [nibble_w-1:0] ram_rdata;
  wire                pc_inc;
  wire                a_we;
  wire                b_we;
  wire                x_we;
  wire                y_we;
  wire                flag_we;
  wire [nibble_w-1:0] wdata;
  wire [addr_w-1:0]   xy_byte;
  wire                carry_in;
  wire                zero_in;

  cpu_core u_core (
    .clk (clk), .rst (rst),
    .rom_data (rom_data), .ram_rdata (ram_rdata),
    .pc (out_pc), .a (out_a), .b (out_b), .x (out_x), .y (out_y), .carry (out_carry),
    .rom_addr (rom_addr), .ram_re (ram_re), .ram_we (io_we),
    .ram_addr (io_addr), .ram_wdata (io_wdata),
    .pc_inc (pc_inc), .a_we (a_we), .b_we (b_we), .x_we (x_we), .y_we (y_we),
    .flag_we (flag_we), .wdata (wdata), .xy_byte (xy_byte),
    .carry_in (carry_in), .zero_in (zero_in), .instr_done (instr_done)
  );

  cpu_regs u_regs (
    .clk (clk), .rst (rst),
    .pc_inc (pc_inc), .a_we (a_we), .b_we (b_we), .x_we (x_we), .y_we (y_we),
    .flag_we (flag_we), .xy_byte (xy_byte), .wdata (wdata),
    .carry_in (carry_in), .zero_in (zero_in),
    .pc (out_pc), .x (out_x), .y (out_y), .a (out_a), .b (out_b),
    .carry (out_carry), .zero (out_zero)
  );

  cpu_ram u_ram (
    .clk (clk), .re (ram_re), .we (io_we),
    .addr (io_addr), .wdata (io_wdata), .rdata (ram_rdata)
  );

endmodule

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_tb import cpu_pkg::*; ();

  logic                clk;
  logic                rst;
  logic [instr_w-1:0]  rom_data;
  wire  [addr_w-1:0]   rom_addr;
  wire  [addr_w-1:0]   out_pc;
  wire  [nibble_w-1:0] out_a;
  wire  [nibble_w-1:0] out_b;
  wire  [addr_w-1:0]   out_x;
  wire  [addr_w-1:0]   out_y;
  wire                 out_carry;
  wire                 out_zero;
  wire                 instr_done;
  wire                 io_we;
  wire  [addr_w-1:0]   io_addr;
  wire  [nibble_w-1:0] io_wdata;

  logic [instr_w-1:0]  rom [1 << addr_w];

  // expected state records, one per instruction.
  logic [127:0]        s_name [$];
  logic [addr_w-1:0]   s_pc [$];
  logic [nibble_w-1:0] s_a [$];
  logic [nibble_w-1:0] s_b [$];
  logic [addr_w-1:0]   s_x [$];
  logic [addr_w-1:0]   s_y [$];
  logic                s_c [$];
  logic                s_z [$];
  logic [2:0]          s_cyc [$];
  // expected io writes.
  logic [127:0]        w_name [$];
  logic [addr_w-1:0]   w_addr [$];
  logic [nibble_w-1:0] w_data [$];

  int   n_s = 0;
  int   n_w = 0;
  int   s_seen = 0;
  int   errors = 0;
  int   test_err = 0;
  int   n_pass = 0;
  int   n_fail = 0;
  int   cyc = 0;
  int   done_cyc = 0;
  logic check_pending = 1'b0;
  logic loaded = 1'b0;

  cpu u_cpu (
    .clk (clk), .rst (rst), .rom_data (rom_data), .rom_addr (rom_addr),
    .out_pc (out_pc), .out_a (out_a), .out_b (out_b), .out_x (out_x), .out_y (out_y),
    .out_carry (out_carry), .out_zero (out_zero), .instr_done (instr_done),
    .io_we (io_we), .io_addr (io_addr), .io_wdata (io_wdata)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_nibble(input string name, input logic [nibble_w-1:0] exp,
                              input logic [nibble_w-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      errors++;
      test_err++;
    end
  endtask

  task automatic check_addr(input string name, input logic [addr_w-1:0] exp,
                            input logic [addr_w-1:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      errors++;
      test_err++;
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      errors++;
      test_err++;
    end
  endtask

  task automatic check_count(input string name, input logic [2:0] exp,
                             input logic [2:0] act);
    if (act !== exp) begin
      $display("CHECK FAILED time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
      errors++;
      test_err++;
    end
  endtask

  // ------------------------------
  // test data
  // ------------------------------
  initial begin : load
    int                  fd;
    int                  code;
    logic [127:0]        tag;
    logic [127:0]        name;
    logic [8*128-1:0]    line;
    logic [addr_w-1:0]   addr;
    logic [instr_w-1:0]  word;
    logic [addr_w-1:0]   pc;
    logic [addr_w-1:0]   x;
    logic [addr_w-1:0]   y;
    logic [nibble_w-1:0] a;
    logic [nibble_w-1:0] b;
    logic                c;
    logic                z;
    int                  len;
    for (int i = 0; i < (1 << addr_w); i++)
      rom[i] = 12'(i) ^ 12'h5a5;
    fd = $fopen("testbench/cpu_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      $display("Simulation failed");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        code = $fscanf(fd, "%s", tag);
        if (code != 1)
          break;
        if (tag == "#") begin
          code = $fgets(line, fd);  // comment line.
        end else if (tag == "P") begin
          code = $fscanf(fd, "%h %h", addr, word);
          rom[addr] = word;
        end else if (tag == "S") begin
          code = $fscanf(fd, "%s %h %h %h %h %h %h %h %d", name, pc, a, b, x, y, c, z, len);
          s_name.push_back(name);
          s_pc.push_back(pc);
          s_a.push_back(a);
          s_b.push_back(b);
          s_x.push_back(x);
          s_y.push_back(y);
          s_c.push_back(c);
          s_z.push_back(z);
          s_cyc.push_back(3'(len));
        end else if (tag == "W") begin
          code = $fscanf(fd, "%s %h %h", name, addr, a);
          w_name.push_back(name);
          w_addr.push_back(addr);
          w_data.push_back(a);
        end else begin
          $display("unknown record %0s in the test data", tag);
          errors++;
        end
      end
      $fclose(fd);
      n_s = s_pc.size();
      n_w = w_addr.size();
      loaded = 1'b1;
    end
  end

  always @(negedge clk)
    rom_data <= rom[rom_addr];

  // ------------------------------
  // monitor, on the falling edge
  // ------------------------------
  always @(negedge clk) begin
    if (check_pending && s_pc.size() > 0) begin
      check_addr("out_pc", s_pc[0], out_pc);
      check_addr("rom_addr", s_pc[0], rom_addr);
      check_nibble("out_a", s_a[0], out_a);
      check_nibble("out_b", s_b[0], out_b);
      check_addr("out_x", s_x[0], out_x);
      check_addr("out_y", s_y[0], out_y);
      check_flag("out_carry", s_c[0], out_carry);
      check_flag("out_zero", s_z[0], out_zero);
      check_count("cycles", s_cyc[0], 3'(done_cyc));
      if (test_err == 0) begin
        $display("test %0s: ok", s_name[0]);
        n_pass++;
      end else begin
        $display("test %0s: %0d errors", s_name[0], test_err);
        n_fail++;
      end
      test_err = 0;
      void'(s_name.pop_front());
      void'(s_pc.pop_front());
      void'(s_a.pop_front());
      void'(s_b.pop_front());
      void'(s_x.pop_front());
      void'(s_y.pop_front());
      void'(s_c.pop_front());
      void'(s_z.pop_front());
      void'(s_cyc.pop_front());
      s_seen++;
    end
    check_pending = 1'b0;
    if (rst)
      cyc = 0;
    cyc++;  // counts the cycle now in progress.
    if (!rst && io_we) begin
      if (w_addr.size() == 0) begin
        $display("io write to %h at %0t was not expected", io_addr, $time);
        errors++;
        test_err++;
      end else begin
        check_addr("io_addr", w_addr[0], io_addr);
        check_nibble("io_wdata", w_data[0], io_wdata);
        void'(w_name.pop_front());
        void'(w_addr.pop_front());
        void'(w_data.pop_front());
      end
    end
    if (!rst && instr_done) begin
      done_cyc = cyc;
      cyc = 0;
      check_pending = 1'b1;  // state settles on the next rising edge.
    end
  end

  // ------------------------------
  // main sequence and watchdog
  // ------------------------------
  initial begin : main
    rst = 1'b1;
    rom_data = '0;
    wait (loaded);
    repeat (4) @(negedge clk);
    rst <= 1'b0;
    wait (s_seen == n_s);
    @(negedge clk);
    while (w_addr.size() > 0) begin
      $display("expected io write of test %0s never happened", w_name[0]);
      errors++;
      void'(w_name.pop_front());
      void'(w_addr.pop_front());
      void'(w_data.pop_front());
    end
    $display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, errors);
    if (errors == 0 && n_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin : watchdog
    wait (loaded);
    #((n_s + n_w) * 7 * 40 + 2000);
    $display("timeout, the program did not finish in time");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/cpu_testdata.txt ====
# P rom_addr word | S test pc a b x y carry zero cycles
# W test io_addr io_wdata
P 100 E01  S ld_a_imm      101 1 0 000 000 0 0 5
P 101 E18  S ld_b_imm      102 1 8 000 000 0 0 5
P 102 AF0  S rlc_a_c0      103 2 8 000 000 0 0 7
P 103 C0F  S add_a_carry   104 1 8 000 000 1 0 7
P 104 AF5  S rlc_b_c1      105 1 1 000 000 1 0 7
P 105 E8C  S rrc_a_c1      106 8 1 000 000 1 0 5
P 106 E8D  S rrc_b_c1      107 8 8 000 000 1 0 5
P 107 C80  S and_a_zero    108 0 8 000 000 1 1 7
P 108 E8C  S rrc_a_zero_c1 109 8 8 000 000 0 0 5
P 109 AF0  S rlc_a_to_zero 10A 0 8 000 000 1 1 7
P 10A E8D  S rrc_b_c1_b    10B 0 C 000 000 0 0 5
P 10B AF5  S rlc_b_c0      10C 0 8 000 000 1 0 7
P 10C B34  S ld_x          10D 0 8 034 000 1 0 5
P 10D 879  S ld_y          10E 0 8 034 079 1 0 5
P 10E E25  S ld_mx_imm     10F 0 8 034 079 1 0 5
W ld_mx_imm 034 5
P 10F AFA  S rlc_mx        110 0 8 034 079 0 0 7
W rlc_mx 034 B
P 110 E39  S ld_my_imm     111 0 8 034 079 0 0 5
W ld_my_imm 079 9
P 111 E8F  S rrc_my        112 0 8 034 079 1 0 5
W rrc_my 079 4
P 112 FFF  S nop7          113 0 8 034 079 1 0 7
P 113 123  S undecoded     114 0 8 034 079 1 0 5
P 114 FFB  S nop5          115 0 8 034 079 1 0 5
P 115 C00  S add_a_zero    116 0 8 034 079 0 1 7
P 116 E8C  S rrc_a_to_zero 117 0 8 034 079 0 1 5
P 117 E8D  S rrc_b_c0      118 0 4 034 079 0 0 5

// ==== list.f ====
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_regs.sv
verilog/cpu_ram.sv
verilog/cpu_core.sv
verilog/cpu.sv
testbench/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the cpu testbench.

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module cpu_tb \
		-Mdir obj_dir -o Vcpu_tb
	./obj_dir/Vcpu_tb | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir
